// ==== verilog/mul_pkg.sv ====
/*
  Shared constants for the multiply accelerator.
  Holds the register map, operation codes, data widths, the pipeline
  depth and the AXI4-Lite response codes. Modules import it as needed.
*/
package mul_pkg;

  // Data path widths
  localparam int word_width = 32;
  localparam int nibble_width = 4;
  localparam int product_width = 2 * word_width;
  localparam int strb_width = word_width / 8;
  localparam int addr_width = 5;

  // Nibble digits per operand and number of digit products
  localparam int digit_count = word_width / nibble_width;
  localparam int pp_count = digit_count * digit_count;

  // Cycles from launch to done
  localparam int mul_latency = 4;

  // Register map, byte offsets
  localparam logic [addr_width-1:0] reg_operand_a = 5'h00;
  localparam logic [addr_width-1:0] reg_operand_b = 5'h04;
  localparam logic [addr_width-1:0] reg_ctrl = 5'h08;
  localparam logic [addr_width-1:0] reg_result = 5'h0C;
  localparam logic [addr_width-1:0] reg_status = 5'h10;

  // Operation select, ctrl bits 2:1
  localparam int op_width = 2;
  localparam logic [op_width-1:0] op_mul = 2'd0;
  localparam logic [op_width-1:0] op_mulh = 2'd1;
  localparam logic [op_width-1:0] op_mulhsu = 2'd2;
  localparam logic [op_width-1:0] op_mulhu = 2'd3;

  // AXI response codes
  localparam int resp_width = 2;
  localparam logic [resp_width-1:0] resp_okay = 2'b00;
  localparam logic [resp_width-1:0] resp_slverr = 2'b10;

endpackage

// ==== verilog/mul_decode.sv ====
/*
  AXI4-Lite write side of the multiply accelerator.
  Stores both operands, takes the control word and turns a start request
  into a one-cycle launch with the signedness and word select for execute.
*/
module mul_decode
(
  input  logic clk,
  input  logic reset,
  input  logic awvalid,
  output logic awready,
  input  logic [mul_pkg::addr_width-1:0] awaddr,
  input  logic wvalid,
  output logic wready,
  input  logic [mul_pkg::word_width-1:0] wdata,
  input  logic [mul_pkg::strb_width-1:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output logic [mul_pkg::resp_width-1:0] bresp,
  input  logic busy,
  output logic launch,
  output logic [mul_pkg::word_width-1:0] operand_a,
  output logic [mul_pkg::word_width-1:0] operand_b,
  output logic [mul_pkg::op_width-1:0] op,
  output logic signed_a,
  output logic signed_b,
  output logic want_high
);
  import mul_pkg::*;

  logic accept;
  logic full_strb;
  logic start_req;
  logic start_ok;
  logic wr_ok;
  logic next_signed_a;
  logic next_signed_b;
  logic next_want_high;

  // Address and data beats are taken together, one response at a time
  assign accept = awvalid && wvalid && !bvalid;
  assign awready = accept;
  assign wready = accept;

  // Partial writes change nothing
  assign full_strb = &wstrb;
  assign start_req = (awaddr == reg_ctrl) && full_strb && wdata[0];

  // Launch still in flight counts as busy, status has not caught up yet
  assign start_ok = accept && start_req && !busy && !launch;

  always_comb
  begin
    case (awaddr)
      reg_operand_a, reg_operand_b: wr_ok = 1'b1;
      // Start while a multiply runs is refused
      reg_ctrl: wr_ok = !(start_req && (busy || launch));
      default: wr_ok = 1'b0;
    endcase
  end

  // Arithmetic controls from the RISC-V variant
  always_comb
  begin
    case (wdata[2:1])
      op_mul:
      begin
        next_signed_a = 1'b1;
        next_signed_b = 1'b1;
        next_want_high = 1'b0;
      end
      op_mulh:
      begin
        next_signed_a = 1'b1;
        next_signed_b = 1'b1;
        next_want_high = 1'b1;
      end
      op_mulhsu:
      begin
        next_signed_a = 1'b1;
        next_signed_b = 1'b0;
        next_want_high = 1'b1;
      end
      default:
      begin
        next_signed_a = 1'b0;
        next_signed_b = 1'b0;
        next_want_high = 1'b1;
      end
    endcase
  end

  // Handshake and launch state
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bvalid <= 1'b0;
      launch <= 1'b0;
    end
    else
    begin
      launch <= start_ok;
      if (accept)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  // Response code and register contents
  always_ff @(posedge clk)
  begin
    if (accept)
      bresp <= wr_ok ? resp_okay : resp_slverr;
    if (accept && full_strb && awaddr == reg_operand_a)
      operand_a <= wdata;
    if (accept && full_strb && awaddr == reg_operand_b)
      operand_b <= wdata;
    // Operation held steady for the whole multiply
    if (start_ok)
    begin
      op <= wdata[2:1];
      signed_a <= next_signed_a;
      signed_b <= next_signed_b;
      want_high <= next_want_high;
    end
  end

endmodule

// ==== verilog/mul_execute.sv ====
/*
  Pipelined 32x32 multiplier built from nibble partial products.
  A launch pulse enters with the operands; done comes out mul_latency
  cycles later with the selected product word and its overflow flag.
*/
module mul_execute
(
  input  logic clk,
  input  logic reset,
  input  logic launch,
  input  logic [mul_pkg::word_width-1:0] operand_a,
  input  logic [mul_pkg::word_width-1:0] operand_b,
  input  logic signed_a,
  input  logic signed_b,
  input  logic want_high,
  output logic done,
  output logic [mul_pkg::word_width-1:0] product_word,
  output logic overflow
);
  import mul_pkg::*;

  // Valid bit travelling beside the data
  logic [mul_latency-1:0] valid_pipe;

  // Partial products and sums per stage
  logic [product_width-1:0] pp1 [pp_count];
  logic [product_width-1:0] sum_32 [pp_count/2];
  logic [product_width-1:0] sum_16 [pp_count/4];
  logic [product_width-1:0] sum_8 [pp_count/8];
  logic [product_width-1:0] s2 [pp_count/4];
  logic [product_width-1:0] s3 [pp_count/16];

  // Operands and {signed_a, signed_b, want_high} kept for the correction
  logic [word_width-1:0] a1, a2, a3;
  logic [word_width-1:0] b1, b2, b3;
  logic [2:0] ctl1, ctl2, ctl3;

  logic [product_width-1:0] full;
  logic ovf_next;

  always_ff @(posedge clk)
  begin
    if (reset)
      valid_pipe <= '0;
    else
      valid_pipe <= {valid_pipe[mul_latency-2:0], launch};
  end

  assign done = valid_pipe[mul_latency-1];

  // Stage 1, every nibble pair times its weight
  always_ff @(posedge clk)
  begin
    a1 <= operand_a;
    b1 <= operand_b;
    ctl1 <= {signed_a, signed_b, want_high};
    for (int i = 0; i < digit_count; i++)
    begin
      for (int j = 0; j < digit_count; j++)
      begin
        pp1[i*digit_count + j] <=
          product_width'(operand_a[i*nibble_width +: nibble_width]) *
          product_width'(operand_b[j*nibble_width +: nibble_width]) <<
          (nibble_width * (i + j));
      end
    end
  end

  // Two adder levels per stage
  always_comb
  begin
    for (int i = 0; i < pp_count/2; i++)
    begin
      sum_32[i] = pp1[2*i] + pp1[2*i + 1];
    end
    for (int i = 0; i < pp_count/8; i++)
    begin
      sum_8[i] = s2[2*i] + s2[2*i + 1];
    end
  end

  always_comb
  begin
    for (int i = 0; i < pp_count/4; i++)
    begin
      sum_16[i] = sum_32[2*i] + sum_32[2*i + 1];
    end
  end

  // Stage 2 and stage 3 registers
  always_ff @(posedge clk)
  begin
    a2 <= a1;
    b2 <= b1;
    ctl2 <= ctl1;
    s2 <= sum_16;
    a3 <= a2;
    b3 <= b2;
    ctl3 <= ctl2;
    for (int i = 0; i < pp_count/16; i++)
    begin
      s3[i] <= sum_8[2*i] + sum_8[2*i + 1];
    end
  end

  // Stage 4, unsigned sum then two's complement correction
  always_comb
  begin
    full = s3[0] + s3[1] + s3[2] + s3[3];
    if (ctl3[2] && a3[word_width-1])
      full = full - {b3, {word_width{1'b0}}};
    if (ctl3[1] && b3[word_width-1])
      full = full - {a3, {word_width{1'b0}}};
    // Mixed sign counts as a signed result
    if (ctl3[2] || ctl3[1])
      ovf_next = full[product_width-1:word_width] != {word_width{full[word_width-1]}};
    else
      ovf_next = full[product_width-1:word_width] != '0;
  end

  always_ff @(posedge clk)
  begin
    product_word <= ctl3[0] ? full[product_width-1:word_width] : full[word_width-1:0];
    overflow <= ovf_next;
  end

endmodule

// ==== verilog/mul_result.sv ====
/*
  Result capture and AXI4-Lite read side of the multiply accelerator.
  Tracks busy from launch to done, holds the last product and overflow,
  and answers reads of the result and status registers.
*/
module mul_result
(
  input  logic clk,
  input  logic reset,
  input  logic launch,
  input  logic done,
  input  logic [mul_pkg::word_width-1:0] product_word,
  input  logic overflow,
  output logic busy,
  input  logic arvalid,
  output logic arready,
  input  logic [mul_pkg::addr_width-1:0] araddr,
  output logic rvalid,
  input  logic rready,
  output logic [mul_pkg::word_width-1:0] rdata,
  output logic [mul_pkg::resp_width-1:0] rresp
);
  import mul_pkg::*;

  logic [word_width-1:0] result_q;
  logic overflow_q;
  logic read_accept;

  // One read outstanding
  assign arready = !rvalid;
  assign read_accept = arvalid && !rvalid;

  // Busy window and captured result
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy <= 1'b0;
      result_q <= '0;
      overflow_q <= 1'b0;
    end
    else
    begin
      if (done)
      begin
        busy <= 1'b0;
        result_q <= product_word;
        overflow_q <= overflow;
      end
      if (launch)
        busy <= 1'b1;
    end
  end

  // Read response held until rready
  always_ff @(posedge clk)
  begin
    if (reset)
      rvalid <= 1'b0;
    else if (read_accept)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (read_accept)
    begin
      case (araddr)
        reg_result:
        begin
          rdata <= result_q;
          rresp <= resp_okay;
        end
        reg_status:
        begin
          rdata <= {{(word_width-2){1'b0}}, overflow_q, busy};
          rresp <= resp_okay;
        end
        default:
        begin
          rdata <= '0;
          rresp <= resp_slverr;
        end
      endcase
    end
  end

endmodule

// ==== verilog/mul_accel.sv ====
/*
  Top level of the multiply accelerator.
  Exposes one AXI4-Lite slave port and connects the write decode,
  the multiplier pipeline and the result and read logic.
*/
module mul_accel
(
  input  logic clk,
  input  logic reset,
  input  logic awvalid,
  output logic awready,
  input  logic [mul_pkg::addr_width-1:0] awaddr,
  input  logic wvalid,
  output logic wready,
  input  logic [mul_pkg::word_width-1:0] wdata,
  input  logic [mul_pkg::strb_width-1:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output logic [mul_pkg::resp_width-1:0] bresp,
  input  logic arvalid,
  output logic arready,
  input  logic [mul_pkg::addr_width-1:0] araddr,
  output logic rvalid,
  input  logic rready,
  output logic [mul_pkg::word_width-1:0] rdata,
  output logic [mul_pkg::resp_width-1:0] rresp
);
  import mul_pkg::*;

  // Decode to execute
  logic launch;
  logic [word_width-1:0] operand_a;
  logic [word_width-1:0] operand_b;
  logic signed_a;
  logic signed_b;
  logic want_high;

  // Execute to result, and busy back to decode
  logic done;
  logic [word_width-1:0] product_word;
  logic overflow;
  logic busy;

  mul_decode mul_decode_inst
  (
    .clk(clk),
    .reset(reset),
    .awvalid(awvalid),
    .awready(awready),
    .awaddr(awaddr),
    .wvalid(wvalid),
    .wready(wready),
    .wdata(wdata),
    .wstrb(wstrb),
    .bvalid(bvalid),
    .bready(bready),
    .bresp(bresp),
    .busy(busy),
    .launch(launch),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .op(),
    .signed_a(signed_a),
    .signed_b(signed_b),
    .want_high(want_high)
  );

  mul_execute mul_execute_inst
  (
    .clk(clk),
    .reset(reset),
    .launch(launch),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .signed_a(signed_a),
    .signed_b(signed_b),
    .want_high(want_high),
    .done(done),
    .product_word(product_word),
    .overflow(overflow)
  );

  mul_result mul_result_inst
  (
    .clk(clk),
    .reset(reset),
    .launch(launch),
    .done(done),
    .product_word(product_word),
    .overflow(overflow),
    .busy(busy),
    .arvalid(arvalid),
    .arready(arready),
    .araddr(araddr),
    .rvalid(rvalid),
    .rready(rready),
    .rdata(rdata),
    .rresp(rresp)
  );

endmodule

// ==== tb/tb_clock.sv ====
/*
  Free-running clock for the testbench.
  Period of 4 time units, starts low.
*/
module tb_clock
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

endmodule

// ==== tb/mul_accel_assertions.sv ====
/*
  Protocol and timing checker for the multiply accelerator.
  Bound into mul_accel; watches the B and R channels and the launch to done latency.
*/
module mul_accel_assertions
(
  input logic clk,
  input logic reset,
  input logic bvalid,
  input logic bready,
  input logic [mul_pkg::resp_width-1:0] bresp,
  input logic rvalid,
  input logic rready,
  input logic [mul_pkg::word_width-1:0] rdata,
  input logic [mul_pkg::resp_width-1:0] rresp,
  input logic launch,
  input logic busy,
  input logic done
);
  import mul_pkg::*;

  int fail_count = 0;

  // Write response held until bready
  b_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
  else
  begin
    $error("B channel response dropped or changed before bready");
    fail_count++;
  end

  // Read response held until rready
  r_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
  else
  begin
    $error("R channel response dropped or changed before rready");
    fail_count++;
  end

  // Fixed pipeline depth, both directions
  done_after_launch: assert property (@(posedge clk) disable iff (reset)
    $past(launch, mul_latency) |-> done)
  else
  begin
    $error("done missing mul_latency cycles after launch");
    fail_count++;
  end

  done_has_launch: assert property (@(posedge clk) disable iff (reset)
    done |-> $past(launch, mul_latency))
  else
  begin
    $error("done without a launch mul_latency cycles earlier");
    fail_count++;
  end

  // Only one multiply in flight
  no_launch_busy: assert property (@(posedge clk) disable iff (reset)
    launch |-> !busy)
  else
  begin
    $error("launch while busy");
    fail_count++;
  end

endmodule

bind mul_accel mul_accel_assertions mul_accel_assertions_inst
(
  .clk(clk),
  .reset(reset),
  .bvalid(bvalid),
  .bready(bready),
  .bresp(bresp),
  .rvalid(rvalid),
  .rready(rready),
  .rdata(rdata),
  .rresp(rresp),
  .launch(launch),
  .busy(busy),
  .done(done)
);

// ==== tb/mul_accel_tb.sv ====
/*
  Testbench for the multiply accelerator.
  Runs every line of the stimulus file through the AXI4-Lite port, then checks
  start rejection while busy, unmapped addresses and the status after reset.
*/
module mul_accel_tb;
  import mul_pkg::*;

  localparam int max_tests = 32;
  localparam int wait_limit = 200;

  logic clk;
  logic reset;
  logic awvalid;
  logic awready;
  logic [addr_width-1:0] awaddr;
  logic wvalid;
  logic wready;
  logic [word_width-1:0] wdata;
  logic [strb_width-1:0] wstrb;
  logic bvalid;
  logic bready;
  logic [resp_width-1:0] bresp;
  logic arvalid;
  logic arready;
  logic [addr_width-1:0] araddr;
  logic rvalid;
  logic rready;
  logic [word_width-1:0] rdata;
  logic [resp_width-1:0] rresp;

  // Five words per line: op, operand_a, operand_b, result, overflow
  logic [word_width-1:0] stim_mem [5*max_tests];
  int errors;
  int tests_run;
  int tests_failed;
  bit timed_out;
  bit stalls_on;
  logic [resp_width-1:0] resp;
  logic [word_width-1:0] data;

  // Handshakes on the AW, W and AR channels, as the DUT sees them
  int aw_count;
  int w_count;
  int ar_count;

  tb_clock tb_clock_inst (.clk(clk));

  mul_accel mul_accel_inst (.*);

  always @(posedge clk)
  begin
    if (awvalid && awready)
      aw_count++;
    if (wvalid && wready)
      w_count++;
    if (arvalid && arready)
      ar_count++;
  end

  // Ready for B and R, random half the time when stalls are on
  function automatic logic draw_ready();
    if (!stalls_on)
      return 1'b1;
    return $urandom_range(0, 1) == 1;
  endfunction

  task automatic expect_word(input string name, input logic [word_width-1:0] got,
    input logic [word_width-1:0] expected);
    if (got !== expected)
    begin
      $display("FAILED %s: got %h, expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic flag_timeout(input string what);
    $display("Timed out waiting for %s", what);
    errors++;
    timed_out = 1'b1;
  endtask

  // Called and returns at a falling edge
  task automatic write_register(input logic [addr_width-1:0] addr,
    input logic [word_width-1:0] value, output logic [resp_width-1:0] resp_out);
    int waited;
    int aw_before;
    int w_before;
    resp_out = 2'b01;
    if (timed_out)
      return;
    aw_before = aw_count;
    w_before = w_count;
    awvalid = 1'b1;
    awaddr = addr;
    wvalid = 1'b1;
    wdata = value;
    wstrb = '1;
    waited = 0;
    // bvalid rises only when address and data are taken
    do
    begin
      @(negedge clk);
      waited++;
    end
    while (!bvalid && waited < wait_limit);
    awvalid = 1'b0;
    wvalid = 1'b0;
    if (!bvalid)
    begin
      flag_timeout("write acceptance");
      return;
    end
    // Address and data each taken exactly once
    expect_word("awready handshakes", word_width'(aw_count - aw_before), 32'd1);
    expect_word("wready handshakes", word_width'(w_count - w_before), 32'd1);
    waited = 0;
    bready = draw_ready();
    while (!bready && waited < wait_limit)
    begin
      @(negedge clk);
      waited++;
      bready = draw_ready();
    end
    resp_out = bresp;
    @(negedge clk);
    bready = 1'b0;
    // One response per write
    if (bvalid)
    begin
      $display("Write response still pending after its handshake");
      errors++;
    end
  endtask

  task automatic read_register(input logic [addr_width-1:0] addr,
    output logic [word_width-1:0] data_out, output logic [resp_width-1:0] resp_out);
    int waited;
    int ar_before;
    data_out = '0;
    resp_out = 2'b01;
    if (timed_out)
      return;
    ar_before = ar_count;
    arvalid = 1'b1;
    araddr = addr;
    waited = 0;
    do
    begin
      @(negedge clk);
      waited++;
    end
    while (!rvalid && waited < wait_limit);
    arvalid = 1'b0;
    if (!rvalid)
    begin
      flag_timeout("read acceptance");
      return;
    end
    expect_word("arready handshakes", word_width'(ar_count - ar_before), 32'd1);
    waited = 0;
    rready = draw_ready();
    while (!rready && waited < wait_limit)
    begin
      @(negedge clk);
      waited++;
      rready = draw_ready();
    end
    data_out = rdata;
    resp_out = rresp;
    @(negedge clk);
    rready = 1'b0;
    if (rvalid)
    begin
      $display("Read response still pending after its handshake");
      errors++;
    end
  endtask

  // Poll status until busy clears
  task automatic wait_idle(output logic [word_width-1:0] status);
    int polls;
    polls = 0;
    status = 32'h1;
    while (status[0] && polls < wait_limit && !timed_out)
    begin
      read_register(reg_status, status, resp);
      polls++;
    end
    if (status[0] && !timed_out)
      flag_timeout("busy to clear");
  endtask

  task automatic close_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("test %s: passed", name);
    else
    begin
      $display("test %s: failed", name);
      tests_failed++;
    end
  endtask

  initial
  begin
    int errors_before;
    int count;
    int last;
    logic [op_width-1:0] op_code;
    logic [word_width-1:0] status;
    void'($urandom(39717));
    reset = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    aw_count = 0;
    w_count = 0;
    ar_count = 0;
    timed_out = 1'b0;
    stalls_on = 1'b1;
    $readmemh("tb/mul_stimulus.txt", stim_mem);
    count = 0;
    while (count < max_tests && stim_mem[5*count] != 32'hff)
      count++;
    last = count - 1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle and cleared after reset
    errors_before = errors;
    read_register(reg_status, data, resp);
    expect_word("rresp", word_width'(resp), word_width'(resp_okay));
    expect_word("status", data, '0);
    read_register(reg_result, data, resp);
    expect_word("rdata", data, '0);
    close_test("status after reset", errors_before);

    // One multiply per stimulus line, with random B and R stalls
    for (int i = 0; i < count; i++)
    begin
      errors_before = errors;
      op_code = stim_mem[5*i][op_width-1:0];
      write_register(reg_operand_a, stim_mem[5*i+1], resp);
      expect_word("bresp", word_width'(resp), word_width'(resp_okay));
      write_register(reg_operand_b, stim_mem[5*i+2], resp);
      expect_word("bresp", word_width'(resp), word_width'(resp_okay));
      write_register(reg_ctrl, word_width'({op_code, 1'b1}), resp);
      expect_word("bresp", word_width'(resp), word_width'(resp_okay));
      wait_idle(status);
      expect_word("status overflow", word_width'(status[1]), stim_mem[5*i+4]);
      read_register(reg_result, data, resp);
      expect_word("rresp", word_width'(resp), word_width'(resp_okay));
      expect_word("rdata", data, stim_mem[5*i+3]);
      close_test($sformatf("line %0d op %0d", i, op_code), errors_before);
    end

    // Second start right behind the first, no stalls so it lands while busy
    errors_before = errors;
    stalls_on = 1'b0;
    op_code = stim_mem[5*last][op_width-1:0];
    write_register(reg_operand_a, stim_mem[5*last+1], resp);
    write_register(reg_operand_b, stim_mem[5*last+2], resp);
    write_register(reg_ctrl, word_width'({op_code, 1'b1}), resp);
    expect_word("bresp", word_width'(resp), word_width'(resp_okay));
    write_register(reg_ctrl, word_width'({~op_code, 1'b1}), resp);
    expect_word("bresp", word_width'(resp), word_width'(resp_slverr));
    stalls_on = 1'b1;
    wait_idle(status);
    read_register(reg_result, data, resp);
    expect_word("rdata", data, stim_mem[5*last+3]);
    close_test("start while busy", errors_before);

    // Unmapped and wrong-direction accesses leave the operands alone
    errors_before = errors;
    write_register(5'h14, 32'h0bad0bad, resp);
    expect_word("bresp", word_width'(resp), word_width'(resp_slverr));
    write_register(reg_result, 32'h0000ffff, resp);
    expect_word("bresp", word_width'(resp), word_width'(resp_slverr));
    read_register(5'h18, data, resp);
    expect_word("rresp", word_width'(resp), word_width'(resp_slverr));
    expect_word("rdata", data, '0);
    read_register(reg_ctrl, data, resp);
    expect_word("rresp", word_width'(resp), word_width'(resp_slverr));
    expect_word("rdata", data, '0);
    write_register(reg_ctrl, word_width'({op_code, 1'b1}), resp);
    wait_idle(status);
    read_register(reg_result, data, resp);
    expect_word("rdata", data, stim_mem[5*last+3]);
    close_test("unmapped access", errors_before);

    errors += mul_accel_inst.mul_accel_assertions_inst.fail_count;
    $display("Tests run %0d, tests failed %0d, failed checks %0d",
      tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== tb/mul_stimulus.txt ====
// Columns: op (0 mul, 1 mulh, 2 mulhsu, 3 mulhu), operand_a, operand_b,
// expected result, expected overflow. A line with op ff ends the list.
0 00000000 00000005 00000000 0
0 00000007 00000006 0000002a 0
0 ffffffff ffffffff 00000001 0
0 80000000 ffffffff 80000000 1
0 00010000 00010000 00000000 1
0 fffffffd 00000004 fffffff4 0
0 12345678 00000010 23456780 1
1 80000000 80000000 40000000 1
1 ffffffff 00000002 ffffffff 0
1 7fffffff 7fffffff 3fffffff 1
2 ffffffff ffffffff ffffffff 1
2 00000001 ffffffff 00000000 1
2 fffffffe 00000003 ffffffff 0
3 ffffffff ffffffff fffffffe 1
3 00000001 00000001 00000000 0
3 80000000 00000002 00000001 1
ff 00000000 00000000 00000000 0

// ==== src.f ====
verilog/mul_pkg.sv
verilog/mul_decode.sv
verilog/mul_execute.sv
verilog/mul_result.sv
verilog/mul_accel.sv
tb/tb_clock.sv
tb/mul_accel_assertions.sv
tb/mul_accel_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the multiply accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module mul_accel_tb \
  -f src.f -o sim_mul_accel
output=$(./obj_dir/sim_mul_accel +verilator+error+limit+100)
echo "$output"
if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
